/* Bender.yml */
package:
  name: softmc

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/softmc_instr_pkg.sv
      - common/ddr3_bus_pkg.sv
      - src/sync_fifo.sv
      - sequencer/instr_sequencer.sv
      - readback/read_capture.sv
      - src/softmc_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/softmc_checker.sv
      - bench/tb_softmc_top.sv

/* bench/softmc_checker.sv */
`timescale 1ns/1ps

module softmc_checker (
  input logic ddr3_ck_n_sdram,
  input logic rst_n,
  input logic app_en,
  input logic app_ack,
  input logic processing_iseq,
  input logic ddr_cs_n,
  input logic ddr_ras_n,
  input logic ddr_cas_n,
  input logic ddr_we_n,
  input logic rdback_fifo_rden,
  input logic rdback_fifo_empty
);

  // Ack only for a strobe on the previous edge
  ack_after_en: assert property (@(posedge ddr3_ck_n_sdram) disable iff (!rst_n)
    app_ack |-> $past(app_en))
    else $error("app_ack without a strobe one cycle earlier");

  // Each command lasts a single cycle
  cs_single_cycle: assert property (@(posedge ddr3_ck_n_sdram) disable iff (!rst_n)
    !ddr_cs_n |=> ddr_cs_n)
    else $error("ddr_cs_n low for more than one cycle");

  // NOP on the pins outside a sequence
  nop_when_idle: assert property (@(posedge ddr3_ck_n_sdram) disable iff (!rst_n)
    !processing_iseq |-> (ddr_cs_n && ddr_ras_n && ddr_cas_n && ddr_we_n))
    else $error("command strobe low while no sequence runs");

  no_pop_when_empty: assert property (@(posedge ddr3_ck_n_sdram) disable iff (!rst_n)
    rdback_fifo_rden |-> !rdback_fifo_empty)
    else $error("readback pop while the FIFO is empty");

endmodule

/* bench/softmc_vectors.txt */
# I: instruction word, D: read response word in read order, F: queue fill word (all hex)
# C: sequence, cycles since previous command (0 = first), cs/ras/cas/we, bank, address
F 40000001
# Sequence 1: ACT, three reads, PRE
I 83401234
I 40000003
I 85400010
I 40000001
I 85400018
I 40000001
I 85400020
I 40000002
I 82400400
I 00000000
# Sequence 2: ACT, two reads, PRE
I 83a00042
I 40000004
I 85a00008
I 40000001
I 85a00010
I 40000005
I 82a00400
I 00000000
D 0123456789abcdef
D fedcba9876543210
D 0f1e2d3c4b5a6978
D a5a5a5a55a5a5a5a
D 13579bdf02468ace
C 1 0 3 2 1234
C 1 4 5 2 0010
C 1 2 5 2 0018
C 1 2 5 2 0020
C 1 3 2 2 0400
C 2 0 3 5 0042
C 2 5 5 5 0008
C 2 2 5 5 0010
C 2 6 2 5 0400

/* bench/tb_softmc_top.sv */
`timescale 1ns/1ps

`include "softmc_settings.svh"

module tb_softmc_top
  import softmc_instr_pkg::*;
  import ddr3_bus_pkg::*;
();

  localparam int CLK_HALF   = 20;
  localparam int LAT        = `SOFTMC_READ_LATENCY;
  localparam int WAIT_LIMIT = 400;

  logic      ddr3_ck_n_sdram;
  logic      rst_n;
  logic      app_en;
  instr_t    app_instr;
  logic      app_ack;
  logic      iq_full;
  logic      processing_iseq;
  logic      ddr_cs_n;
  logic      ddr_ras_n;
  logic      ddr_cas_n;
  logic      ddr_we_n;
  ddr_bank_t ddr_ba;
  ddr_addr_t ddr_addr;
  dq_word_t  ddr_dq;
  logic      rdback_fifo_rden;
  dq_word_t  rdback_data;
  logic      rdback_fifo_empty;

  // Contents of the vector file
  instr_t     fill_word;
  instr_t     instr_list[$];
  dq_word_t   read_words[$];
  int         cmd_seq[$];
  int         cmd_gap[$];
  logic [3:0] cmd_pins[$];
  ddr_bank_t  cmd_ba[$];
  ddr_addr_t  cmd_addr[$];
  int         seq_count;

  // Pin monitor state
  int         cyc;
  int         cmd_idx;
  int         last_cmd_cyc;
  int         seq_done;
  int         rd_seen;
  logic       prev_proc;
  int         resp_due[$];
  dq_word_t   resp_word[$];

  softmc_top u_dut (.*);

  bind softmc_top softmc_checker u_checker (
    .ddr3_ck_n_sdram   (ddr3_ck_n_sdram),
    .rst_n             (rst_n),
    .app_en            (app_en),
    .app_ack           (app_ack),
    .processing_iseq   (processing_iseq),
    .ddr_cs_n          (ddr_cs_n),
    .ddr_ras_n         (ddr_ras_n),
    .ddr_cas_n         (ddr_cas_n),
    .ddr_we_n          (ddr_we_n),
    .rdback_fifo_rden  (rdback_fifo_rden),
    .rdback_fifo_empty (rdback_fifo_empty)
  );

  initial begin
    ddr3_ck_n_sdram = 1'b0;
    forever #CLK_HALF ddr3_ck_n_sdram = ~ddr3_ck_n_sdram;
  end

  // ************************************************************************
  // Reporting
  // ************************************************************************

  task automatic report_failure(input string line);
    $display("%s", line);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // ************************************************************************
  // Vector file
  // ************************************************************************

  task automatic load_vectors();
    int         fd;
    int         n;
    byte        tag;
    string      rest;
    instr_t     w;
    dq_word_t   d;
    int         seq;
    int         gap;
    logic [3:0] pins;
    ddr_bank_t  ba;
    ddr_addr_t  addr;
    fd = $fopen("bench/softmc_vectors.txt", "r");
    if (fd == 0) begin
      report_failure("could not open bench/softmc_vectors.txt");
    end
    while ($fscanf(fd, " %c", tag) == 1) begin
      case (tag)
        "#": n = $fgets(rest, fd);
        "F": n = $fscanf(fd, " %h", fill_word);
        "I": begin
          n = $fscanf(fd, " %h", w);
          instr_list.push_back(w);
          // END opcode closes one sequence
          if (w[31:28] == 4'b0000) begin
            seq_count++;
          end
        end
        "D": begin
          n = $fscanf(fd, " %h", d);
          read_words.push_back(d);
        end
        "C": begin
          n = $fscanf(fd, " %d %d %h %h %h", seq, gap, pins, ba, addr);
          if (n != 5) begin
            report_failure("malformed command record in the vector file");
          end
          cmd_seq.push_back(seq);
          cmd_gap.push_back(gap);
          cmd_pins.push_back(pins);
          cmd_ba.push_back(ba);
          cmd_addr.push_back(addr);
        end
        default: report_failure($sformatf("unknown record tag %c in the vector file", tag));
      endcase
    end
    $fclose(fd);
  endtask

  function automatic int count_cmds_through(input int seq);
    int n;
    n = 0;
    foreach (cmd_seq[i]) begin
      if (cmd_seq[i] <= seq) begin
        n++;
      end
    end
    return n;
  endfunction

  // ************************************************************************
  // Pin monitor and read responder
  // ************************************************************************

  task automatic record_command();
    if (cmd_idx >= cmd_pins.size()) begin
      report_failure("a command appeared on the pins after the expected list was used up");
    end
    check_value("command sequence", seq_done + 1, cmd_seq[cmd_idx]);
    check_value("ddr cs_n/ras_n/cas_n/we_n", {ddr_cs_n, ddr_ras_n, ddr_cas_n, ddr_we_n},
                cmd_pins[cmd_idx]);
    check_value("ddr_ba", ddr_ba, cmd_ba[cmd_idx]);
    check_value("ddr_addr", ddr_addr, cmd_addr[cmd_idx]);
    check_value("processing_iseq", processing_iseq, 1'b1);
    if (cmd_gap[cmd_idx] == 0) begin
      check_value("processing_iseq before first command", prev_proc, 1'b1);
    end else begin
      check_value("command spacing", cyc - last_cmd_cyc, cmd_gap[cmd_idx]);
    end
    last_cmd_cyc = cyc;
    // Read is cs_n=0 ras_n=1 cas_n=0 we_n=1
    if (ddr_ras_n && !ddr_cas_n && ddr_we_n) begin
      if (rd_seen >= read_words.size()) begin
        report_failure("a read was issued with no response word left");
      end
      resp_due.push_back(cyc + LAT);
      resp_word.push_back(read_words[rd_seen]);
      rd_seen++;
    end
    cmd_idx++;
  endtask

  initial begin
    ddr_dq       = '0;
    cyc          = 0;
    cmd_idx      = 0;
    last_cmd_cyc = 0;
    seq_done     = 0;
    rd_seen      = 0;
    prev_proc    = 1'b0;
    forever begin
      @(negedge ddr3_ck_n_sdram);
      cyc++;
      if ((resp_due.size() != 0) && (resp_due[0] == cyc)) begin
        ddr_dq = resp_word.pop_front();
        void'(resp_due.pop_front());
      end else begin
        ddr_dq = '0;
      end
      if (rst_n) begin
        if (ddr_cs_n === 1'b0) begin
          record_command();
        end else begin
          check_value("ddr ras_n/cas_n/we_n on NOP", {ddr_ras_n, ddr_cas_n, ddr_we_n}, 3'b111);
        end
        // End of a sequence
        if (prev_proc && !processing_iseq) begin
          seq_done++;
          check_value("commands at sequence end", cmd_idx, count_cmds_through(seq_done));
        end
        prev_proc = processing_iseq;
      end else begin
        prev_proc = 1'b0;
      end
    end
  end

  // ************************************************************************
  // Stimulus
  // ************************************************************************

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (3) @(negedge ddr3_ck_n_sdram);
    rst_n = 1'b1;
  endtask

  task automatic check_idle_outputs();
    check_value("ddr cs_n/ras_n/cas_n/we_n", {ddr_cs_n, ddr_ras_n, ddr_cas_n, ddr_we_n}, 4'hf);
    check_value("app_ack", app_ack, 1'b0);
    check_value("processing_iseq", processing_iseq, 1'b0);
    check_value("iq_full", iq_full, 1'b0);
    check_value("rdback_fifo_empty", rdback_fifo_empty, 1'b1);
  endtask

  // Strobe for one cycle and expect the ack exactly one cycle later
  task automatic send_instr(input instr_t w, input logic exp_ack);
    app_en    = 1'b1;
    app_instr = w;
    @(negedge ddr3_ck_n_sdram);
    app_en = 1'b0;
    check_value("app_ack", app_ack, exp_ack);
    @(negedge ddr3_ck_n_sdram);
    check_value("app_ack after pulse", app_ack, 1'b0);
  endtask

  task automatic fill_queue();
    for (int i = 0; i < `SOFTMC_IQ_DEPTH; i++) begin
      check_value("iq_full", iq_full, 1'b0);
      send_instr(fill_word, 1'b1);
    end
    check_value("iq_full", iq_full, 1'b1);
    send_instr(fill_word, 1'b0);
    check_value("iq_full", iq_full, 1'b1);
  endtask

  task automatic send_program();
    foreach (instr_list[i]) begin
      send_instr(instr_list[i], 1'b1);
    end
  endtask

  task automatic drain_readback();
    int gap;
    int t;
    for (int k = 0; k < read_words.size(); k++) begin
      gap = $urandom % 4;
      repeat (gap) @(negedge ddr3_ck_n_sdram);
      t = 0;
      while (rdback_fifo_empty) begin
        @(negedge ddr3_ck_n_sdram);
        t++;
        if (t > WAIT_LIMIT) begin
          report_failure($sformatf("timeout waiting for readback word %0d", k));
        end
      end
      check_value("rdback_data", rdback_data, read_words[k]);
      rdback_fifo_rden = 1'b1;
      @(negedge ddr3_ck_n_sdram);
      rdback_fifo_rden = 1'b0;
    end
  endtask

  task automatic wait_sequences_done();
    int t;
    t = 0;
    while (seq_done < seq_count) begin
      @(negedge ddr3_ck_n_sdram);
      t++;
      if (t > WAIT_LIMIT) begin
        report_failure("timeout waiting for the queued sequences to finish");
      end
    end
  endtask

  initial begin
    rst_n            = 1'b0;
    app_en           = 1'b0;
    app_instr        = '0;
    rdback_fifo_rden = 1'b0;
    seq_count        = 0;
    void'($urandom(32'h1e1));
    load_vectors();
    repeat (3) @(negedge ddr3_ck_n_sdram);
    rst_n = 1'b1;
    check_idle_outputs();

    // Fill the queue without END and clear it by reset
    fill_queue();
    apply_reset();
    check_idle_outputs();

    fork
      send_program();
      drain_readback();
    join
    wait_sequences_done();

    check_value("command count", cmd_idx, cmd_pins.size());
    check_value("read count", rd_seen, read_words.size());
    check_value("rdback_fifo_empty", rdback_fifo_empty, 1'b1);
    check_value("processing_iseq", processing_iseq, 1'b0);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* common/ddr3_bus_pkg.sv */
`include "softmc_settings.svh"

package ddr3_bus_pkg;

  // Bank address pins
  typedef logic [`SOFTMC_BANK_WIDTH-1:0] ddr_bank_t;

  // Row or column address on shared pins
  typedef logic [`SOFTMC_ROW_WIDTH-1:0] ddr_addr_t;

  // One word from the data bus
  typedef logic [`SOFTMC_DQ_WIDTH-1:0] dq_word_t;

endpackage

/* common/softmc_instr_pkg.sv */
`include "softmc_settings.svh"

package softmc_instr_pkg;

  // ************************************************************************
  // Instruction word
  // ************************************************************************

  typedef logic [31:0] instr_t;

  // Top nibble of the instruction word
  typedef enum logic [3:0] {
    OP_END  = 4'b0000,
    OP_WAIT = 4'b0100,
    OP_DDR  = 4'b1000
  } opcode_e;

  // Idle cycles carried in bits 27..0 of a WAIT
  typedef logic [27:0] wait_cnt_t;

  // Room for one END per queue entry
  typedef logic [$clog2(`SOFTMC_IQ_DEPTH + 1)-1:0] end_cnt_t;

  // ************************************************************************
  // Sequencer
  // ************************************************************************

  typedef enum logic [1:0] {
    SEQ_IDLE  = 2'd0,
    SEQ_ISSUE = 2'd1,
    SEQ_WAIT  = 2'd2
  } seq_state_e;

endpackage

/* common/softmc_settings.svh */
`ifndef SOFTMC_SETTINGS_SVH
`define SOFTMC_SETTINGS_SVH

// Queue depths in entries
`define SOFTMC_IQ_DEPTH      16
`define SOFTMC_RDBACK_DEPTH  8

// Cycles from a read command on the pins to the sampled data word
`define SOFTMC_READ_LATENCY  5

// DDR3 pin widths
`define SOFTMC_ROW_WIDTH     15
`define SOFTMC_BANK_WIDTH    3
`define SOFTMC_DQ_WIDTH      64

`endif

/* compile.f */
+incdir+common
common/softmc_instr_pkg.sv
common/ddr3_bus_pkg.sv
src/sync_fifo.sv
sequencer/instr_sequencer.sv
readback/read_capture.sv
src/softmc_top.sv
bench/softmc_checker.sv
bench/tb_softmc_top.sv

/* readback/read_capture.sv */
`timescale 1ns/1ps

`include "softmc_settings.svh"

module read_capture
  import ddr3_bus_pkg::*;
(
  input  logic     ddr3_ck_n_sdram,
  input  logic     rst_n,

  // Issued command pins
  input  logic     ddr_cs_n,
  input  logic     ddr_ras_n,
  input  logic     ddr_cas_n,
  input  logic     ddr_we_n,
  input  dq_word_t ddr_dq,

  // Toward the readback FIFO
  output logic     capture,
  output dq_word_t capture_data
);

  localparam int LAT = `SOFTMC_READ_LATENCY;

  logic           is_read;
  logic [LAT-1:0] rd_pipe;

  // READ is cs_n=0 ras_n=1 cas_n=0 we_n=1
  assign is_read = !ddr_cs_n && ddr_ras_n && !ddr_cas_n && ddr_we_n;

  // ************************************************************************
  // Read marker pipeline
  // ************************************************************************

  // Bit k is set k+1 cycles after the read was on the pins
  always_ff @(posedge ddr3_ck_n_sdram) begin
    if (!rst_n) begin
      rd_pipe <= '0;
      capture <= 1'b0;
    end else begin
      rd_pipe <= {rd_pipe[LAT-2:0], is_read};
      capture <= rd_pipe[LAT-1];
    end
  end

  // Data is valid on the bus while the oldest marker is set
  always_ff @(posedge ddr3_ck_n_sdram) begin
    if (rd_pipe[LAT-1]) begin
      capture_data <= ddr_dq;
    end
  end

endmodule

/* sequencer/instr_sequencer.sv */
`timescale 1ns/1ps

module instr_sequencer
  import softmc_instr_pkg::*;
  import ddr3_bus_pkg::*;
(
  input  logic      ddr3_ck_n_sdram,
  input  logic      rst_n,

  // Queue side
  input  logic      push,
  input  opcode_e   push_opcode,
  input  instr_t    instr,
  input  logic      iq_empty,
  output logic      iq_pop,
  output logic      processing_iseq,

  // Registered command pins
  output logic      ddr_cs_n,
  output logic      ddr_ras_n,
  output logic      ddr_cas_n,
  output logic      ddr_we_n,
  output ddr_bank_t ddr_ba,
  output ddr_addr_t ddr_addr
);

  seq_state_e state;
  end_cnt_t   end_pending;
  wait_cnt_t  wait_left;
  opcode_e    op;
  wait_cnt_t  instr_wait;
  logic       fetch;
  logic       issue_ddr;
  logic       end_pushed;
  logic       end_popped;

  // ************************************************************************
  // Decode of the queue head
  // ************************************************************************

  assign op         = opcode_e'(instr[31:28]);
  assign instr_wait = instr[27:0];

  // One instruction per cycle while issuing
  assign fetch      = (state == SEQ_ISSUE) && !iq_empty;
  assign iq_pop     = fetch;
  assign issue_ddr  = fetch && (op == OP_DDR);

  assign end_pushed = push && (push_opcode == OP_END);
  assign end_popped = fetch && (op == OP_END);

  assign processing_iseq = (state != SEQ_IDLE);

  // ************************************************************************
  // Pending END count
  // ************************************************************************

  // Each queued END marks one complete sequence ready to run
  always_ff @(posedge ddr3_ck_n_sdram) begin
    if (!rst_n) begin
      end_pending <= '0;
    end else begin
      case ({end_pushed, end_popped})
        2'b10:   end_pending <= end_pending + 1'b1;
        2'b01:   end_pending <= end_pending - 1'b1;
        default: end_pending <= end_pending;
      endcase
    end
  end

  // ************************************************************************
  // Sequence FSM
  // ************************************************************************

  // WAIT n takes its own fetch cycle plus n-1 idle cycles
  always_ff @(posedge ddr3_ck_n_sdram) begin
    if (!rst_n) begin
      state     <= SEQ_IDLE;
      wait_left <= '0;
    end else begin
      case (state)
        SEQ_IDLE: begin
          if (end_pending != '0) begin
            state <= SEQ_ISSUE;
          end
        end
        SEQ_ISSUE: begin
          // WAIT 0 behaves as WAIT 1 and needs no idle state
          if (fetch) begin
            if (op == OP_END) begin
              state <= SEQ_IDLE;
            end else if ((op == OP_WAIT) && (instr_wait > wait_cnt_t'(1))) begin
              wait_left <= instr_wait - 1'b1;
              state     <= SEQ_WAIT;
            end
          end
        end
        SEQ_WAIT: begin
          wait_left <= wait_left - 1'b1;
          if (wait_left <= wait_cnt_t'(1)) begin
            state <= SEQ_ISSUE;
          end
        end
        default: begin
          state <= SEQ_IDLE;
        end
      endcase
    end
  end

  // ************************************************************************
  // Command pins
  // ************************************************************************

  // NOP on every cycle without a DDR instruction
  always_ff @(posedge ddr3_ck_n_sdram) begin
    if (!rst_n) begin
      ddr_cs_n  <= 1'b1;
      ddr_ras_n <= 1'b1;
      ddr_cas_n <= 1'b1;
      ddr_we_n  <= 1'b1;
    end else if (issue_ddr) begin
      ddr_cs_n  <= instr[27];
      ddr_ras_n <= instr[26];
      ddr_cas_n <= instr[25];
      ddr_we_n  <= instr[24];
    end else begin
      ddr_cs_n  <= 1'b1;
      ddr_ras_n <= 1'b1;
      ddr_cas_n <= 1'b1;
      ddr_we_n  <= 1'b1;
    end
  end

  // Bank and address only mean something under cs_n low
  always_ff @(posedge ddr3_ck_n_sdram) begin
    if (issue_ddr) begin
      ddr_ba   <= instr[23:21];
      ddr_addr <= instr[14:0];
    end
  end

endmodule

/* src/softmc_top.sv */
`timescale 1ns/1ps

`include "softmc_settings.svh"

module softmc_top
  import softmc_instr_pkg::*;
  import ddr3_bus_pkg::*;
(
  input  logic      ddr3_ck_n_sdram,
  input  logic      rst_n,

  // Instruction port
  input  logic      app_en,
  input  instr_t    app_instr,
  output logic      app_ack,
  output logic      iq_full,
  output logic      processing_iseq,

  // DDR3 command and data pins
  output logic      ddr_cs_n,
  output logic      ddr_ras_n,
  output logic      ddr_cas_n,
  output logic      ddr_we_n,
  output ddr_bank_t ddr_ba,
  output ddr_addr_t ddr_addr,
  input  dq_word_t  ddr_dq,

  // Readback port
  input  logic      rdback_fifo_rden,
  output dq_word_t  rdback_data,
  output logic      rdback_fifo_empty
);

  logic     iq_push;
  logic     iq_pop;
  logic     iq_empty;
  instr_t   iq_head;
  logic     capture;
  dq_word_t capture_data;

  // A strobe while full is lost without an acknowledge
  assign iq_push = app_en && !iq_full;

  always_ff @(posedge ddr3_ck_n_sdram) begin
    if (!rst_n) begin
      app_ack <= 1'b0;
    end else begin
      app_ack <= iq_push;
    end
  end

  // ************************************************************************
  // Instruction path
  // ************************************************************************

  sync_fifo #(
    .WIDTH ($bits(instr_t)),
    .DEPTH (`SOFTMC_IQ_DEPTH)
  ) u_instr_queue (
    .ddr3_ck_n_sdram (ddr3_ck_n_sdram),
    .rst_n           (rst_n),
    .push            (iq_push),
    .push_data       (app_instr),
    .pop             (iq_pop),
    .head            (iq_head),
    .empty           (iq_empty),
    .full            (iq_full)
  );

  instr_sequencer u_instr_sequencer (
    .ddr3_ck_n_sdram (ddr3_ck_n_sdram),
    .rst_n           (rst_n),
    .push            (iq_push),
    .push_opcode     (opcode_e'(app_instr[31:28])),
    .instr           (iq_head),
    .iq_empty        (iq_empty),
    .iq_pop          (iq_pop),
    .processing_iseq (processing_iseq),
    .ddr_cs_n        (ddr_cs_n),
    .ddr_ras_n       (ddr_ras_n),
    .ddr_cas_n       (ddr_cas_n),
    .ddr_we_n        (ddr_we_n),
    .ddr_ba          (ddr_ba),
    .ddr_addr        (ddr_addr)
  );

  // ************************************************************************
  // Readback path
  // ************************************************************************

  read_capture u_read_capture (
    .ddr3_ck_n_sdram (ddr3_ck_n_sdram),
    .rst_n           (rst_n),
    .ddr_cs_n        (ddr_cs_n),
    .ddr_ras_n       (ddr_ras_n),
    .ddr_cas_n       (ddr_cas_n),
    .ddr_we_n        (ddr_we_n),
    .ddr_dq          (ddr_dq),
    .capture         (capture),
    .capture_data    (capture_data)
  );

  sync_fifo #(
    .WIDTH (`SOFTMC_DQ_WIDTH),
    .DEPTH (`SOFTMC_RDBACK_DEPTH)
  ) u_rdback_fifo (
    .ddr3_ck_n_sdram (ddr3_ck_n_sdram),
    .rst_n           (rst_n),
    .push            (capture),
    .push_data       (capture_data),
    .pop             (rdback_fifo_rden),
    .head            (rdback_data),
    .empty           (rdback_fifo_empty),
    .full            ()
  );

endmodule

/* src/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 16
) (
  input  logic             ddr3_ck_n_sdram,
  input  logic             rst_n,
  input  logic             push,
  input  logic [WIDTH-1:0] push_data,
  input  logic             pop,
  output logic [WIDTH-1:0] head,
  output logic             empty,
  output logic             full
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);
  localparam logic [CW-1:0] FULL_CNT = CW'(DEPTH);
  localparam logic [AW-1:0] LAST_PTR = AW'(DEPTH - 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [CW-1:0]    count;
  logic             do_push;
  logic             do_pop;

  // Wraps at DEPTH even when it is not a power of two
  function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
    if (ptr == LAST_PTR) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Full queue drops the push and empty queue ignores the pop
  assign do_push = push && (count != FULL_CNT);
  assign do_pop  = pop && (count != '0);

  assign empty = (count == '0);
  assign full  = (count == FULL_CNT);

  // First word falls through
  assign head = mem[rd_ptr];

  always_ff @(posedge ddr3_ck_n_sdram) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge ddr3_ck_n_sdram) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule
